/* ucode_context_load.f */
common/isa_pkg.sv
common/uop_pkg.sv
src/context_cfg_regs.sv
microcode/ucode_rom.sv
microcode/ucode_sequencer.sv
src/ucode_context_load.sv
tb/uop_monitor.sv
tb/ucode_context_load_checker.sv
tb/tb_ucode_context_load.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_ucode_context_load -f ucode_context_load.f

./obj_dir/Vtb_ucode_context_load +verilator+error+limit+100 | tee sim.log

if grep -q "^All tests passed$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* tb/tb_ucode_context_load.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ucode_context_load;

	typedef enum logic [1:0] {READY_ALWAYS, READY_ALT, READY_RAND} ready_mode_t;

	logic clock, rst, start_valid, uop_ready, cfg_wr_en;
	logic [uop_pkg::CFG_ADDR_W-1:0] cfg_wr_addr;
	logic [uop_pkg::DATA_W-1:0] cfg_wr_data;
	logic start_ready, uop_valid, uop_last, uop_commit_wait;
	logic [uop_pkg::UCODE_IDX_W-1:0] uop_index;
	logic [isa_pkg::CC_W-1:0] uop_cond;
	logic [isa_pkg::LOGICREG_W-1:0] uop_src0, uop_dest;
	logic [uop_pkg::DATA_W-1:0] uop_src1;
	logic uop_src1_imm, uop_src0_active, uop_src1_active, uop_src0_sysreg, uop_src1_sysreg;
	logic uop_wb_en, uop_dest_sysreg, uop_dest_rename;
	logic [isa_pkg::EXE_CMD_W-1:0] uop_exe_cmd;
	logic [isa_pkg::EXE_SEL_W-1:0] uop_exe_sel;
	logic [uop_pkg::DATA_W-1:0] exp_base, exp_stride;	// Values rows 1 and 3 must carry
	int mismatch_count, xfer_count;
	int run_errors = 0;
	int start_count = 0;	// Accepted starts
	int busy_cycles = 0;	// Cycles with start_ready low in this run
	int cycle_count = 0;
	int cycle_limit;
	int rnd;
	integer seed = 32'h57ec;
	ready_mode_t mode = READY_ALWAYS;
	ready_mode_t mode_now;

	// Per run config write flag, base, stride, ready pattern and worst ready stretch
	logic run_write [5] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
	logic [31:0] run_base [5] = '{uop_pkg::CFG_BASE_RESET, 32'h0000_1000, 32'h0000_0040,
		32'hffff_fff0, 32'hffff_fff0};
	logic [31:0] run_stride [5] = '{uop_pkg::CFG_STRIDE_RESET, 32'd256, 32'hdead_0010,
		32'd72, 32'd72};
	ready_mode_t run_mode [5] = '{READY_ALWAYS, READY_ALT, READY_RAND, READY_ALWAYS, READY_RAND};
	int run_stretch [5] = '{1, 2, 8, 1, 8};

	ucode_context_load uut (.*);
	uop_monitor u_monitor (.*);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock)
	begin
		mode_now = mode;	// Pattern fixed before the drive point
		#5;
		case (mode_now)
			READY_ALWAYS: uop_ready = 1'b1;
			READY_ALT: uop_ready = ~uop_ready;
			default:
			begin
				rnd = $random(seed);
				uop_ready = rnd[0];
			end
		endcase
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (!rst && start_valid && start_ready)
			start_count++;
		if (!rst && !start_ready)
			busy_cycles++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles, a load never finished", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	task write_cfg(input logic [31:0] base, input logic [31:0] stride);
		cfg_wr_en = 1'b1;
		cfg_wr_addr = uop_pkg::CFG_ADDR_BASE;
		cfg_wr_data = base;
		@(posedge clock);
		#5;
		cfg_wr_addr = uop_pkg::CFG_ADDR_STRIDE;
		cfg_wr_data = stride;
		@(posedge clock);
		#5;
		cfg_wr_en = 1'b0;
	endtask

	initial
	begin
		int total;
		rst = 1'b1;
		start_valid = 1'b0;
		uop_ready = 1'b0;
		cfg_wr_en = 1'b0;
		cfg_wr_addr = '0;
		cfg_wr_data = '0;
		exp_base = uop_pkg::CFG_BASE_RESET;
		exp_stride = uop_pkg::CFG_STRIDE_RESET;
		cycle_limit = 0;
		foreach (run_stretch[i])
			cycle_limit += uop_pkg::UCODE_LEN * run_stretch[i];
		cycle_limit = 4 * cycle_limit + 16;
		repeat (16) @(posedge clock);
		#5;
		rst = 1'b0;
		if (!start_ready || uop_valid || uop_last)
		begin
			run_errors++;
			$display("MISMATCH at %0t: idle state wrong after reset", $time);
		end
		foreach (run_write[r])
		begin
			if (run_write[r])
			begin
				start_valid = 1'b0;	// Config only changes while idle
				write_cfg(run_base[r], run_stride[r]);
			end
			exp_base = run_base[r];
			exp_stride = run_stride[r];
			mode = run_mode[r];
			busy_cycles = 0;
			start_valid = 1'b1;	// Held high through the load
			do
			begin
				@(posedge clock);
				#5;
			end
			while (xfer_count < (r + 1) * uop_pkg::UCODE_LEN);
			if (start_count != r + 1)
			begin
				run_errors++;
				$display("MISMATCH at %0t: run %0d saw %0d starts", $time, r, start_count);
			end
			if (run_mode[r] == READY_ALWAYS && busy_cycles != uop_pkg::UCODE_LEN)
			begin
				run_errors++;
				$display("MISMATCH at %0t: run %0d busy %0d cycles", $time, r, busy_cycles);
			end
		end
		total = mismatch_count + run_errors + uut.u_checker.assert_fails;
		$display("Done: %0d transfers, %0d row mismatches, %0d run errors, %0d assert fails",
			xfer_count, mismatch_count, run_errors, uut.u_checker.assert_fails);
		if (total == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/ucode_context_load_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ucode_context_load_checker (
	input wire logic clock,
	input wire logic rst,
	input wire logic start_ready,
	input wire logic uop_valid,
	input wire logic uop_ready,
	input wire logic uop_last,
	input wire logic [uop_pkg::UCODE_IDX_W + uop_pkg::DATA_W + 2 * isa_pkg::LOGICREG_W
		+ isa_pkg::CC_W + isa_pkg::EXE_CMD_W + isa_pkg::EXE_SEL_W + 9 - 1:0] uop_fields
);

	int assert_fails = 0;	// Failed assertion count

	// Held row must not change until taken
	held_row_stable: assert property (@(posedge clock) disable iff (rst)
		uop_valid && !uop_ready |=> uop_valid && $stable(uop_fields))
	else
	begin
		assert_fails++;
		$error("Row changed or was dropped while uop_ready was low");
	end

	// Taking the branch row drops back to idle
	idle_after_last: assert property (@(posedge clock) disable iff (rst)
		uop_valid && uop_ready && uop_last |=> start_ready && !uop_valid)
	else
	begin
		assert_fails++;
		$error("Sequencer did not return to idle after the last row");
	end

	last_needs_valid: assert property (@(posedge clock) disable iff (rst)
		uop_last |-> uop_valid)
	else
	begin
		assert_fails++;
		$error("uop_last high without uop_valid");
	end

endmodule

bind ucode_context_load ucode_context_load_checker u_checker (
	.clock(clock),
	.rst(rst),
	.start_ready(start_ready),
	.uop_valid(uop_valid),
	.uop_ready(uop_ready),
	.uop_last(uop_last),
	.uop_fields({uop_index, uop_commit_wait, uop_cond, uop_src0, uop_src1, uop_src1_imm,
		uop_src0_active, uop_src1_active, uop_src0_sysreg, uop_src1_sysreg, uop_dest,
		uop_wb_en, uop_dest_sysreg, uop_dest_rename, uop_exe_cmd, uop_exe_sel})
);

`default_nettype wire

/* tb/uop_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module uop_monitor (
	input wire logic clock,
	input wire logic rst,
	input wire logic start_valid,
	input wire logic start_ready,
	input wire logic uop_valid,
	input wire logic uop_ready,
	input wire logic uop_last,
	input wire logic [uop_pkg::UCODE_IDX_W-1:0] uop_index,
	input wire logic uop_commit_wait,
	input wire logic [isa_pkg::CC_W-1:0] uop_cond,
	input wire logic [isa_pkg::LOGICREG_W-1:0] uop_src0,
	input wire logic [uop_pkg::DATA_W-1:0] uop_src1,
	input wire logic uop_src1_imm,
	input wire logic uop_src0_active,
	input wire logic uop_src1_active,
	input wire logic uop_src0_sysreg,
	input wire logic uop_src1_sysreg,
	input wire logic [isa_pkg::LOGICREG_W-1:0] uop_dest,
	input wire logic uop_wb_en,
	input wire logic uop_dest_sysreg,
	input wire logic uop_dest_rename,
	input wire logic [isa_pkg::EXE_CMD_W-1:0] uop_exe_cmd,
	input wire logic [isa_pkg::EXE_SEL_W-1:0] uop_exe_sel,
	input wire logic [uop_pkg::DATA_W-1:0] exp_base,	// Last written base offset
	input wire logic [uop_pkg::DATA_W-1:0] exp_stride,	// Last written stride
	output int mismatch_count,
	output int xfer_count
);

	int exp_idx;	// Next row due
	logic start_seen;	// Start taken on previous edge
	logic last_seen;	// Row 42 taken on previous edge
	logic e_commit_wait, e_src1_imm, e_src0_active, e_src1_active;
	logic e_src0_sysreg, e_src1_sysreg, e_wb_en, e_dest_sysreg, e_dest_rename;
	logic [isa_pkg::CC_W-1:0] e_cond;
	logic [isa_pkg::LOGICREG_W-1:0] e_src0;
	logic [isa_pkg::LOGICREG_W-1:0] e_dest;
	logic [uop_pkg::DATA_W-1:0] e_src1;
	logic [isa_pkg::EXE_CMD_W-1:0] e_exe_cmd;
	logic [isa_pkg::EXE_SEL_W-1:0] e_exe_sel;

	task flag(input string what);
		mismatch_count++;
		$display("MISMATCH at %0t: %s", $time, what);
	endtask

	task compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: row %0d field %s got %0h expected %0h",
				$time, exp_idx, name, got, exp);
		end
	endtask

	// Row rules of the context-load sequence
	task expected_row(input int idx);
		e_commit_wait = 1'b0;
		e_cond = isa_pkg::CC_NONE;
		e_src0 = '0;
		e_src1 = '0;
		e_src1_imm = 1'b0;
		e_src0_active = 1'b0;
		e_src1_active = 1'b0;
		e_src0_sysreg = 1'b0;
		e_src1_sysreg = 1'b0;
		e_dest = '0;
		e_wb_en = 1'b1;	// Write-back on by default
		e_dest_sysreg = 1'b0;
		e_dest_rename = 1'b1;	// Rename on by default
		e_exe_cmd = '0;
		e_exe_sel = '0;
		if (idx == 0 || idx == 2 || idx == 40)
		begin
			e_commit_wait = 1'b1;	// Sysreg buffer moves
			e_src0_active = 1'b1;
			e_src0_sysreg = 1'b1;
			e_src0 = (idx == 0) ? isa_pkg::SYSREG_TISR
				: (idx == 2) ? isa_pkg::SYSREG_TIDR : isa_pkg::SYSREG_SSR0;
			e_dest = (idx == 0) ? isa_pkg::R0 : (idx == 2) ? isa_pkg::R1 : isa_pkg::SYSREG_PDTR;
			e_dest_sysreg = (idx == 40);
			e_exe_cmd = isa_pkg::EXE_SYS_REG_BUFFER0;
			e_exe_sel = isa_pkg::EXE_SELECT_SYS_REG;
		end
		else if (idx == 1 || idx == 3 || idx == 4)
		begin
			e_src0_active = 1'b1;	// Frame address arithmetic
			e_src1_active = 1'b1;
			e_src0 = (idx == 3) ? isa_pkg::R1 : isa_pkg::R0;
			e_dest = e_src0;
			e_src1 = (idx == 1) ? exp_base
				: (idx == 3) ? exp_stride : uop_pkg::DATA_W'(isa_pkg::R1);
			e_src1_imm = (idx != 4);
			e_exe_cmd = (idx == 3) ? isa_pkg::EXE_MULDIV_MULL : isa_pkg::EXE_ADDER_ADD;
			e_exe_sel = (idx == 3) ? isa_pkg::EXE_SELECT_MUL : isa_pkg::EXE_SELECT_ADDER;
		end
		else if (idx == 5 || idx == 41)
		begin
			e_src0_active = 1'b1;	// SP writes
			e_src0 = (idx == 5) ? isa_pkg::R0 : isa_pkg::SYSREG_SSR1;
			e_src0_sysreg = (idx == 41);
			e_dest = isa_pkg::SYSREG_SPR;
			e_dest_sysreg = 1'b1;
			e_dest_rename = (idx == 41);	// Frame SP write not renamed
			e_exe_cmd = isa_pkg::EXE_SYS_LDST_WRITE_SPR;
			e_exe_sel = isa_pkg::EXE_SELECT_SYS_LDST;
		end
		else if (idx >= 6 && idx <= 39)
		begin
			e_src1 = uop_pkg::DATA_W'(isa_pkg::SYSREG_SPR);	// Pops
			e_src1_active = 1'b1;
			e_src1_sysreg = 1'b1;
			if (idx <= 8)
			begin
				e_dest = (idx == 6) ? isa_pkg::SSR0 : (idx == 7) ? isa_pkg::SSR1 : isa_pkg::SSR2;
				e_dest_sysreg = 1'b1;
			end
			else
				e_dest = isa_pkg::LOGICREG_W'(40 - idx);	// R31 on row 9 down to R1 on row 39
			e_exe_cmd = isa_pkg::EXE_LDSW_POP;
			e_exe_sel = isa_pkg::EXE_SELECT_LDST;
		end
		else if (idx == 42)
		begin
			e_cond = isa_pkg::CC_AL;	// Jump to saved PC
			e_src1 = uop_pkg::DATA_W'(isa_pkg::SYSREG_SSR2);
			e_src1_active = 1'b1;
			e_src1_sysreg = 1'b1;
			e_dest = isa_pkg::SYSREG_PCR;
			e_dest_sysreg = 1'b1;
			e_wb_en = 1'b0;
			e_exe_cmd = isa_pkg::EXE_BRANCH_DJMP;
			e_exe_sel = isa_pkg::EXE_SELECT_BRANCH;
		end
	endtask

	always @(posedge clock)
	begin
		if (rst)
		begin
			mismatch_count = 0;
			xfer_count = 0;
			exp_idx = 0;
			start_seen = 1'b0;
			last_seen = 1'b0;
		end
		else
		begin
			if (start_seen && !(uop_valid && uop_index == '0))
				flag("row 0 not presented in the cycle after start");
			if (last_seen && !start_ready)
				flag("start_ready still low after the last row");
			if (uop_valid && uop_ready)
			begin
				expected_row(exp_idx);
				compare("uop_index", uop_index, exp_idx);
				compare("uop_last", uop_last, exp_idx == uop_pkg::UCODE_LEN - 1);
				compare("uop_commit_wait", uop_commit_wait, e_commit_wait);
				compare("uop_cond", uop_cond, e_cond);
				compare("uop_src0", uop_src0, e_src0);
				compare("uop_src1", uop_src1, e_src1);
				compare("uop_src1_imm", uop_src1_imm, e_src1_imm);
				compare("uop_src0_active", uop_src0_active, e_src0_active);
				compare("uop_src1_active", uop_src1_active, e_src1_active);
				compare("uop_src0_sysreg", uop_src0_sysreg, e_src0_sysreg);
				compare("uop_src1_sysreg", uop_src1_sysreg, e_src1_sysreg);
				compare("uop_dest", uop_dest, e_dest);
				compare("uop_wb_en", uop_wb_en, e_wb_en);
				compare("uop_dest_sysreg", uop_dest_sysreg, e_dest_sysreg);
				compare("uop_dest_rename", uop_dest_rename, e_dest_rename);
				compare("uop_exe_cmd", uop_exe_cmd, e_exe_cmd);
				compare("uop_exe_sel", uop_exe_sel, e_exe_sel);
				xfer_count++;
				exp_idx = (exp_idx == uop_pkg::UCODE_LEN - 1) ? 0 : exp_idx + 1;
			end
			last_seen = uop_valid && uop_ready && uop_last;
			start_seen = start_valid && start_ready;
			if (start_seen)
				exp_idx = 0;	// New load starts at row 0
		end
	end

endmodule

`default_nettype wire

/* src/ucode_context_load.sv */
`timescale 1ns/1ps
`default_nettype none

module ucode_context_load (
	input wire logic clock,
	input wire logic rst,
	input wire logic start_valid,
	output logic start_ready,
	output logic uop_valid,
	input wire logic uop_ready,
	output logic uop_last,
	output logic [uop_pkg::UCODE_IDX_W-1:0] uop_index,
	output logic uop_commit_wait,
	output logic [isa_pkg::CC_W-1:0] uop_cond,
	output logic [isa_pkg::LOGICREG_W-1:0] uop_src0,
	output logic [uop_pkg::DATA_W-1:0] uop_src1,
	output logic uop_src1_imm,
	output logic uop_src0_active,
	output logic uop_src1_active,
	output logic uop_src0_sysreg,
	output logic uop_src1_sysreg,
	output logic [isa_pkg::LOGICREG_W-1:0] uop_dest,
	output logic uop_wb_en,
	output logic uop_dest_sysreg,
	output logic uop_dest_rename,
	output logic [isa_pkg::EXE_CMD_W-1:0] uop_exe_cmd,
	output logic [isa_pkg::EXE_SEL_W-1:0] uop_exe_sel,
	input wire logic cfg_wr_en,
	input wire logic [uop_pkg::CFG_ADDR_W-1:0] cfg_wr_addr,
	input wire logic [uop_pkg::DATA_W-1:0] cfg_wr_data
);

	logic [uop_pkg::DATA_W-1:0] base_offset;	// Frame base immediate
	logic [uop_pkg::DATA_W-1:0] frame_stride;	// Per-task frame size

	ucode_sequencer u_seq (
		.clock(clock),
		.rst(rst),
		.start_valid(start_valid),
		.start_ready(start_ready),
		.uop_valid(uop_valid),
		.uop_ready(uop_ready),
		.uop_last(uop_last),
		.uop_index(uop_index)
	);

	// Fields follow the index with no register stage
	ucode_rom u_rom (
		.uop_index(uop_index),
		.base_offset(base_offset),
		.frame_stride(frame_stride),
		.uop_commit_wait(uop_commit_wait),
		.uop_cond(uop_cond),
		.uop_src0(uop_src0),
		.uop_src1(uop_src1),
		.uop_src1_imm(uop_src1_imm),
		.uop_src0_active(uop_src0_active),
		.uop_src1_active(uop_src1_active),
		.uop_src0_sysreg(uop_src0_sysreg),
		.uop_src1_sysreg(uop_src1_sysreg),
		.uop_dest(uop_dest),
		.uop_wb_en(uop_wb_en),
		.uop_dest_sysreg(uop_dest_sysreg),
		.uop_dest_rename(uop_dest_rename),
		.uop_exe_cmd(uop_exe_cmd),
		.uop_exe_sel(uop_exe_sel)
	);

	context_cfg_regs u_cfg (
		.clock(clock),
		.rst(rst),
		.cfg_wr_en(cfg_wr_en),
		.cfg_wr_addr(cfg_wr_addr),
		.cfg_wr_data(cfg_wr_data),
		.base_offset(base_offset),
		.frame_stride(frame_stride)
	);

endmodule

`default_nettype wire

/* microcode/ucode_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ucode_sequencer (
	input wire logic clock,
	input wire logic rst,
	input wire logic start_valid,
	output logic start_ready,
	output logic uop_valid,
	input wire logic uop_ready,
	output logic uop_last,
	output logic [uop_pkg::UCODE_IDX_W-1:0] uop_index
);

	logic busy;	// Load in progress
	logic [uop_pkg::UCODE_IDX_W-1:0] entry_cnt;	// Row being presented
	logic start_xfer;
	logic uop_xfer;
	logic at_last;

	assign start_xfer = start_valid && start_ready;
	assign uop_xfer = uop_valid && uop_ready;
	assign at_last = (entry_cnt == uop_pkg::UCODE_LAST);

	// Idle means ready for the next start
	assign start_ready = !busy;
	assign uop_valid = busy;	// Row is held until taken
	assign uop_last = at_last;	// Counter sits at row 0 while idle
	assign uop_index = entry_cnt;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			entry_cnt <= '0;
		end
		else if (start_xfer)
		begin
			busy <= 1'b1;	// Entry 0 shows next cycle
			entry_cnt <= '0;
		end
		else if (uop_xfer)
		begin
			if (at_last)
			begin
				busy <= 1'b0;	// Back to idle after the branch row
				entry_cnt <= '0;
			end
			else
				entry_cnt <= entry_cnt + 1'b1;	// No bubble between rows
		end
	end

endmodule

`default_nettype wire

/* microcode/ucode_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module ucode_rom (
	input wire logic [uop_pkg::UCODE_IDX_W-1:0] uop_index,
	input wire logic [uop_pkg::DATA_W-1:0] base_offset,
	input wire logic [uop_pkg::DATA_W-1:0] frame_stride,
	output logic uop_commit_wait,
	output logic [isa_pkg::CC_W-1:0] uop_cond,
	output logic [isa_pkg::LOGICREG_W-1:0] uop_src0,
	output logic [uop_pkg::DATA_W-1:0] uop_src1,
	output logic uop_src1_imm,
	output logic uop_src0_active,
	output logic uop_src1_active,
	output logic uop_src0_sysreg,
	output logic uop_src1_sysreg,
	output logic [isa_pkg::LOGICREG_W-1:0] uop_dest,
	output logic uop_wb_en,
	output logic uop_dest_sysreg,
	output logic uop_dest_rename,
	output logic [isa_pkg::EXE_CMD_W-1:0] uop_exe_cmd,
	output logic [isa_pkg::EXE_SEL_W-1:0] uop_exe_sel
);

	// Register number placed in the low bits of the source 1 word
	function automatic logic [uop_pkg::DATA_W-1:0] reg_word(
		input logic [isa_pkg::LOGICREG_W-1:0] r
	);
		reg_word = {{(uop_pkg::DATA_W - isa_pkg::LOGICREG_W){1'b0}}, r};
	endfunction

	logic [isa_pkg::LOGICREG_W-1:0] pop_gpr;	// R31 on first GPR pop, R1 on last

	assign pop_gpr = isa_pkg::R31 - isa_pkg::LOGICREG_W'(uop_index - uop_pkg::ROW_POP_GPR_FIRST);

	always_comb
	begin
		uop_commit_wait = 1'b0;	// All zero unless a row sets it
		uop_cond = isa_pkg::CC_NONE;
		uop_src0 = '0;
		uop_src1 = '0;
		uop_src1_imm = 1'b0;
		uop_src0_active = 1'b0;
		uop_src1_active = 1'b0;
		uop_src0_sysreg = 1'b0;
		uop_src1_sysreg = 1'b0;
		uop_dest = '0;
		uop_wb_en = 1'b0;
		uop_dest_sysreg = 1'b0;
		uop_dest_rename = 1'b0;
		uop_exe_cmd = '0;
		uop_exe_sel = '0;
		case (uop_index) inside
			uop_pkg::ROW_RD_TISR, uop_pkg::ROW_RD_TIDR:
			begin
				uop_commit_wait = 1'b1;	// Sysreg read must wait for commit
				uop_src0 = (uop_index == uop_pkg::ROW_RD_TISR) ? isa_pkg::SYSREG_TISR
					: isa_pkg::SYSREG_TIDR;
				uop_src0_active = 1'b1;
				uop_src0_sysreg = 1'b1;
				uop_dest = (uop_index == uop_pkg::ROW_RD_TISR) ? isa_pkg::R0 : isa_pkg::R1;
				uop_wb_en = 1'b1;
				uop_dest_rename = 1'b1;
				uop_exe_cmd = isa_pkg::EXE_SYS_REG_BUFFER0;
				uop_exe_sel = isa_pkg::EXE_SELECT_SYS_REG;
			end
			uop_pkg::ROW_ADD_BASE, uop_pkg::ROW_ADD_REG:
			begin
				uop_src0 = isa_pkg::R0;
				uop_src1 = (uop_index == uop_pkg::ROW_ADD_BASE) ? base_offset
					: reg_word(isa_pkg::R1);	// Frame offset into R0
				uop_src1_imm = (uop_index == uop_pkg::ROW_ADD_BASE);
				uop_src0_active = 1'b1;
				uop_src1_active = 1'b1;
				uop_dest = isa_pkg::R0;
				uop_wb_en = 1'b1;
				uop_dest_rename = 1'b1;
				uop_exe_cmd = isa_pkg::EXE_ADDER_ADD;
				uop_exe_sel = isa_pkg::EXE_SELECT_ADDER;
			end
			uop_pkg::ROW_MUL_STRIDE:
			begin
				uop_src0 = isa_pkg::R1;	// Task ID times stride
				uop_src1 = frame_stride;
				uop_src1_imm = 1'b1;
				uop_src0_active = 1'b1;
				uop_src1_active = 1'b1;
				uop_dest = isa_pkg::R1;
				uop_wb_en = 1'b1;
				uop_dest_rename = 1'b1;
				uop_exe_cmd = isa_pkg::EXE_MULDIV_MULL;
				uop_exe_sel = isa_pkg::EXE_SELECT_MUL;
			end
			uop_pkg::ROW_WR_SPR, uop_pkg::ROW_WR_SPR_SAVED:
			begin
				uop_src0 = (uop_index == uop_pkg::ROW_WR_SPR) ? isa_pkg::R0
					: isa_pkg::SYSREG_SSR1;
				uop_src0_active = 1'b1;
				uop_src0_sysreg = (uop_index == uop_pkg::ROW_WR_SPR_SAVED);
				uop_dest = isa_pkg::SYSREG_SPR;
				uop_wb_en = 1'b1;
				uop_dest_sysreg = 1'b1;
				// Frame SP not renamed
				uop_dest_rename = (uop_index == uop_pkg::ROW_WR_SPR_SAVED);
				uop_exe_cmd = isa_pkg::EXE_SYS_LDST_WRITE_SPR;
				uop_exe_sel = isa_pkg::EXE_SELECT_SYS_LDST;
			end
			[uop_pkg::ROW_POP_SSR_FIRST:uop_pkg::ROW_POP_GPR_LAST]:
			begin
				uop_src1 = reg_word(isa_pkg::SYSREG_SPR);	// Pop through SP
				uop_src1_active = 1'b1;
				uop_src1_sysreg = 1'b1;
				if (uop_index <= uop_pkg::ROW_POP_SSR_LAST)
				begin
					uop_dest = isa_pkg::SSR0
						+ isa_pkg::LOGICREG_W'(uop_index - uop_pkg::ROW_POP_SSR_FIRST);
					uop_dest_sysreg = 1'b1;
				end
				else
					uop_dest = pop_gpr;
				uop_wb_en = 1'b1;
				uop_dest_rename = 1'b1;
				uop_exe_cmd = isa_pkg::EXE_LDSW_POP;
				uop_exe_sel = isa_pkg::EXE_SELECT_LDST;
			end
			uop_pkg::ROW_WR_PDTR:
			begin
				uop_commit_wait = 1'b1;	// Translation change is serializing
				uop_src0 = isa_pkg::SYSREG_SSR0;
				uop_src0_active = 1'b1;
				uop_src0_sysreg = 1'b1;
				uop_dest = isa_pkg::SYSREG_PDTR;
				uop_wb_en = 1'b1;
				uop_dest_sysreg = 1'b1;
				uop_dest_rename = 1'b1;
				uop_exe_cmd = isa_pkg::EXE_SYS_REG_BUFFER0;
				uop_exe_sel = isa_pkg::EXE_SELECT_SYS_REG;
			end
			uop_pkg::ROW_BRANCH:
			begin
				uop_cond = isa_pkg::CC_AL;	// Jump to saved PC
				uop_src1 = reg_word(isa_pkg::SYSREG_SSR2);
				uop_src1_active = 1'b1;
				uop_src1_sysreg = 1'b1;
				uop_dest = isa_pkg::SYSREG_PCR;
				uop_dest_sysreg = 1'b1;
				uop_dest_rename = 1'b1;
				uop_exe_cmd = isa_pkg::EXE_BRANCH_DJMP;
				uop_exe_sel = isa_pkg::EXE_SELECT_BRANCH;
			end
			default:
				;	// Out of table so every field stays zero
		endcase
	end

endmodule

`default_nettype wire

/* src/context_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module context_cfg_regs (
	input wire logic clock,
	input wire logic rst,
	input wire logic cfg_wr_en,
	input wire logic [uop_pkg::CFG_ADDR_W-1:0] cfg_wr_addr,
	input wire logic [uop_pkg::DATA_W-1:0] cfg_wr_data,
	output logic [uop_pkg::DATA_W-1:0] base_offset,
	output logic [uop_pkg::DATA_W-1:0] frame_stride
);

	logic wr_base;
	logic wr_stride;

	// Address decode
	assign wr_base = cfg_wr_en && (cfg_wr_addr == uop_pkg::CFG_ADDR_BASE);
	assign wr_stride = cfg_wr_en && (cfg_wr_addr == uop_pkg::CFG_ADDR_STRIDE);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			base_offset <= uop_pkg::CFG_BASE_RESET;
			frame_stride <= uop_pkg::CFG_STRIDE_RESET;
		end
		else
		begin
			if (wr_base)
				base_offset <= cfg_wr_data;	// Seen by row 1 next cycle
			if (wr_stride)
				frame_stride <= cfg_wr_data;	// Seen by row 3 next cycle
		end
	end

endmodule

`default_nettype wire

/* common/uop_pkg.sv */
`default_nettype none

package uop_pkg;

	// Datapath and immediate width
	localparam int DATA_W = 32;

	// Context-load table
	localparam int UCODE_LEN = 43;
	localparam int UCODE_IDX_W = 6;	// Enough for 43 rows
	localparam logic [UCODE_IDX_W-1:0] UCODE_LAST = UCODE_IDX_W'(UCODE_LEN - 1);

	// Fixed rows of the sequence
	localparam logic [UCODE_IDX_W-1:0] ROW_RD_TISR = 6'd0;
	localparam logic [UCODE_IDX_W-1:0] ROW_ADD_BASE = 6'd1;
	localparam logic [UCODE_IDX_W-1:0] ROW_RD_TIDR = 6'd2;
	localparam logic [UCODE_IDX_W-1:0] ROW_MUL_STRIDE = 6'd3;
	localparam logic [UCODE_IDX_W-1:0] ROW_ADD_REG = 6'd4;
	localparam logic [UCODE_IDX_W-1:0] ROW_WR_SPR = 6'd5;
	localparam logic [UCODE_IDX_W-1:0] ROW_POP_SSR_FIRST = 6'd6;
	localparam logic [UCODE_IDX_W-1:0] ROW_POP_SSR_LAST = 6'd8;
	localparam logic [UCODE_IDX_W-1:0] ROW_POP_GPR_FIRST = 6'd9;	// Pops R31 here
	localparam logic [UCODE_IDX_W-1:0] ROW_POP_GPR_LAST = 6'd39;	// Pops R1 here
	localparam logic [UCODE_IDX_W-1:0] ROW_WR_PDTR = 6'd40;
	localparam logic [UCODE_IDX_W-1:0] ROW_WR_SPR_SAVED = 6'd41;
	localparam logic [UCODE_IDX_W-1:0] ROW_BRANCH = 6'd42;

	// Configuration block
	localparam int CFG_ADDR_W = 1;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_BASE = 1'b0;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_STRIDE = 1'b1;

	// 128 byte header plus 140 byte slot area
	localparam logic [DATA_W-1:0] CFG_BASE_RESET = 32'd268;
	// Bytes per saved task frame
	localparam logic [DATA_W-1:0] CFG_STRIDE_RESET = 32'd144;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	localparam int LOGICREG_W = 5;	// Register number width
	localparam int EXE_SEL_W = 3;
	localparam int EXE_CMD_W = 5;
	localparam int CC_W = 4;

	// General registers
	localparam logic [LOGICREG_W-1:0] R0 = 5'd0, R1 = 5'd1, R2 = 5'd2, R3 = 5'd3,
		R4 = 5'd4, R5 = 5'd5, R6 = 5'd6, R7 = 5'd7,
		R8 = 5'd8, R9 = 5'd9, R10 = 5'd10, R11 = 5'd11,
		R12 = 5'd12, R13 = 5'd13, R14 = 5'd14, R15 = 5'd15,
		R16 = 5'd16, R17 = 5'd17, R18 = 5'd18, R19 = 5'd19,
		R20 = 5'd20, R21 = 5'd21, R22 = 5'd22, R23 = 5'd23,
		R24 = 5'd24, R25 = 5'd25, R26 = 5'd26, R27 = 5'd27,
		R28 = 5'd28, R29 = 5'd29, R30 = 5'd30, R31 = 5'd31;

	localparam logic [LOGICREG_W-1:0] SYSREG_SPR = 5'h01;	// Stack pointer
	localparam logic [LOGICREG_W-1:0] SYSREG_PDTR = 5'h02;	// Page table base
	localparam logic [LOGICREG_W-1:0] SYSREG_PCR = 5'h05;	// Program counter
	localparam logic [LOGICREG_W-1:0] SYSREG_TISR = 5'h09;	// Task stack info
	localparam logic [LOGICREG_W-1:0] SYSREG_TIDR = 5'h0a;	// Task ID
	localparam logic [LOGICREG_W-1:0] SYSREG_SSR0 = 5'h1d;
	localparam logic [LOGICREG_W-1:0] SYSREG_SSR1 = 5'h1e;
	localparam logic [LOGICREG_W-1:0] SYSREG_SSR2 = 5'h1f;

	// Pop targets for the saved system slots share the sysreg numbering
	localparam logic [LOGICREG_W-1:0] SSR0 = SYSREG_SSR0;
	localparam logic [LOGICREG_W-1:0] SSR1 = SYSREG_SSR1;
	localparam logic [LOGICREG_W-1:0] SSR2 = SYSREG_SSR2;

	localparam logic [EXE_SEL_W-1:0] EXE_SELECT_SYS_REG = 3'd0;
	localparam logic [EXE_SEL_W-1:0] EXE_SELECT_ADDER = 3'd1;
	localparam logic [EXE_SEL_W-1:0] EXE_SELECT_MUL = 3'd2;
	localparam logic [EXE_SEL_W-1:0] EXE_SELECT_SYS_LDST = 3'd3;
	localparam logic [EXE_SEL_W-1:0] EXE_SELECT_LDST = 3'd4;
	localparam logic [EXE_SEL_W-1:0] EXE_SELECT_BRANCH = 3'd5;

	localparam logic [EXE_CMD_W-1:0] EXE_SYS_REG_BUFFER0 = 5'h00;	// Sysreg read into GPR
	localparam logic [EXE_CMD_W-1:0] EXE_ADDER_ADD = 5'h01;
	localparam logic [EXE_CMD_W-1:0] EXE_MULDIV_MULL = 5'h02;	// Low word of product
	localparam logic [EXE_CMD_W-1:0] EXE_SYS_LDST_WRITE_SPR = 5'h03;
	localparam logic [EXE_CMD_W-1:0] EXE_LDSW_POP = 5'h04;
	localparam logic [EXE_CMD_W-1:0] EXE_BRANCH_DJMP = 5'h05;	// Direct jump

	localparam logic [CC_W-1:0] CC_NONE = 4'h0;
	localparam logic [CC_W-1:0] CC_AL = 4'he;	// Always taken

endpackage

`default_nettype wire
